/* Makefile */
# Verilator build and run for the control unit testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = controlUnitTb
FILELIST  = src.f
OBJDIR    = obj_dir
SIM       = $(OBJDIR)/V$(TOP)
LOG       = sim.log
PASSMSG   = sim passed
FAILMSG   = sim failed

SOURCES = $(shell grep -v '^+' $(FILELIST)) $(wildcard source/*.svh)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	! grep -q "$(FAILMSG)" $(LOG)
	grep -q "$(PASSMSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* src.f */
+incdir+source
source/isaPkg.sv
source/controlPkg.sv
source/opcodeDecoder.sv
source/controlSequencer.sv
source/controlWordGen.sv
source/controlUnit.sv
test/controlChecker.sv
test/controlUnitTb.sv

/* test/controlUnitTb.sv */
// control unit testbench
// clock, reset, LFSR driven program, watchdog, DUT and checker

`timescale 1ns/10ps
`include "cpu_config.svh"

module controlUnitTb
	import isaPkg::*, controlPkg::*;
();

	localparam int PROG_LEN   = 40;                         // stop included
	localparam int TIMEOUT_NS = PROG_LEN * 5 * 10 + 200;
	// every class and the old vector codes, in front of the random part
	localparam logic [59:0] FIXED_CODES = 60'hACEB73F46802D59;

	logic                      clock;
	logic                      reset;
	logic                      n;
	logic                      z;
	opcodeT                    instr;
	memCtrlT                   memCtrl;
	regCtrlT                   regCtrl;
	aluCtrlT                   aluCtrl;
	logic [`COUNTER_WIDTH-1:0] counter;
	int                        errorCount;
	logic                      stopSeen;

	logic [31:0] lfsrState;
	logic [3:0]  codeList [PROG_LEN];
	int          nextIdx;
	logic        fetchSeen;     // last negedge was inside a fetch

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic drawBits(input int count, output logic [31:0] value);
		value = '0;
		repeat (count)
		begin
			lfsrState = lfsrStep(lfsrState);
			value     = {value[30:0], lfsrState[0]};
		end
	endtask

	task automatic buildProgram();
		logic [31:0] value;
		for (int i = 0; i < PROG_LEN - 1; i++)
		begin
			if (i < 15)
				codeList[i] = FIXED_CODES[59 - 4 * i -: 4];
			else
			begin
				do
					drawBits(4, value);
				while (value[3:0] == 4'b0001);  // stop only at the end
				codeList[i] = value[3:0];
			end
		end
		codeList[PROG_LEN - 1] = 4'b0001;
	endtask

	// new flags every cycle, next opcode the cycle after irLoad
	task automatic driveCycle();
		logic [31:0] bits;
		@(negedge clock);
		drawBits(2, bits);
		n = bits[1];
		z = bits[0];
		if (fetchSeen && nextIdx < PROG_LEN)
		begin
			instr   = opcodeT'(codeList[nextIdx]);
			nextIdx = nextIdx + 1;
		end
		fetchSeen = regCtrl.irLoad;
	endtask

	// --------------------
	// clock and watchdog
	// --------------------
	initial
	begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	initial
	begin
		#(TIMEOUT_NS);
		$display("timeout: the DUT did not reach the stop state within %0d ns", TIMEOUT_NS);
		$display("sim failed");
		$finish;
	end

	// --------------------
	// stimulus
	// --------------------
	initial
	begin
		reset     = 1'b1;
		instr     = opLoad;
		n         = 1'b0;
		z         = 1'b0;
		lfsrState = 32'h29d5eeff;
		nextIdx   = 0;
		fetchSeen = 1'b0;
		buildProgram();
		repeat (5) @(negedge clock);
		reset = 1'b0;
		while (!stopSeen)
			driveCycle();
		repeat (10) driveCycle();   // stop must stay quiet
		scoreboard.printSummary();
		if (errorCount == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

	controlUnit DUT
	(
		.clock   (clock),
		.reset   (reset),
		.instr   (instr),
		.n       (n),
		.z       (z),
		.memCtrl (memCtrl),
		.regCtrl (regCtrl),
		.aluCtrl (aluCtrl),
		.counter (counter)
	);

	controlChecker scoreboard
	(
		.clock      (clock),
		.reset      (reset),
		.instr      (instr),
		.n          (n),
		.z          (z),
		.memCtrl    (memCtrl),
		.regCtrl    (regCtrl),
		.aluCtrl    (aluCtrl),
		.counter    (counter),
		.errorCount (errorCount),
		.stopSeen   (stopSeen)
	);

endmodule

/* test/controlChecker.sv */
// control unit checker
// reference control words, cycle tracking per instruction,
// comparisons and the per-test report

`timescale 1ns/10ps
`include "cpu_config.svh"

module controlChecker
	import isaPkg::*, controlPkg::*;
(
	input  logic                      clock,
	input  logic                      reset,
	input  opcodeT                    instr,
	input  logic                      n,
	input  logic                      z,
	input  memCtrlT                   memCtrl,
	input  regCtrlT                   regCtrl,
	input  aluCtrlT                   aluCtrl,
	input  logic [`COUNTER_WIDTH-1:0] counter,
	output int                        errorCount,
	output logic                      stopSeen
);

	logic [3:0]                curOp;
	logic [`COUNTER_WIDTH-1:0] edgeTally;  // edges since release, stop excluded
	logic                      started;
	int                        idx;
	int                        expLen;
	int                        samples;
	int                        instrNo;
	int                        testErrors;
	int                        testCount;
	int                        testFails;
	int                        checkCount;
	string                     testName;
	memCtrlT                   expMem;
	regCtrlT                   expReg;
	aluCtrlT                   expAlu;

	initial
	begin
		errorCount = 0;
		testErrors = 0;
		testCount  = 0;
		testFails  = 0;
		checkCount = 0;
		stopSeen   = 1'b0;
	end

	// expected word for cycle cyc of an instruction, plus its length
	function automatic void refControl(input logic [3:0] op, input int cyc, input logic nIn,
		input logic zIn, output memCtrlT m, output regCtrlT r, output aluCtrlT a, output int len);
		instrClassT cls;
		aluOpT      arith;
		m     = '0;
		r     = '0;
		a     = '0;
		arith = (op == 4'b0100) ? aluAdd : (op == 4'b0110) ? aluSub : aluNand;
		if (op[2:0] == 3'b011)
			cls = classShift;
		else if (op[2:0] == 3'b111)
			cls = classOri;
		else
		begin
			case (op)
				4'b0100, 4'b0110, 4'b1000: cls = classArith;
				4'b0000: cls = classLoad;
				4'b0010: cls = classStore;
				4'b1101: cls = classBpz;
				4'b0101: cls = classBz;
				4'b1001: cls = classBnz;
				4'b0001: cls = classStop;
				default: cls = classIllegal;
			endcase
		end
		case (cls)
			classOri:                        len = 5;
			classArith, classShift, classLoad: len = 4;
			classStop:                       len = 0;  // no further fetch
			default:                         len = 3;
		endcase
		if (cyc == 0 || (len != 0 && cyc >= len))
		begin
			r.pcWrite = 1'b1;
			r.irLoad  = 1'b1;
			m.addrSel = 1'b1;
			m.memRead = 1'b1;
			a.aluSrc2 = src2One;
		end
		else if (cyc == 1)
			r.r1R2Load = 1'b1;
		else
		begin
			case (cls)
				classArith, classShift:
				begin
					a.alu1        = (cyc == 2);
					a.aluOutWrite = (cyc == 2);
					a.flagWrite   = (cyc == 2);
					r.rfWrite     = (cyc == 3);
					if (cyc == 2)
						a.aluOp = (cls == classArith) ? arith : aluShift;
					if (cyc == 2 && cls == classShift)
						a.aluSrc2 = src2Shamt;
				end
				classOri:
				begin
					r.r1Sel       = (cyc != 3);
					r.r1R2Load    = (cyc == 2);
					r.rfWrite     = (cyc == 4);
					a.alu1        = (cyc == 3);
					a.aluOutWrite = (cyc == 3);
					a.flagWrite   = (cyc == 3);
					if (cyc == 3)
					begin
						a.aluSrc2 = src2Imm;
						a.aluOp   = aluOr;
					end
				end
				classLoad:
				begin
					m.memRead     = (cyc == 2);
					m.mdrLoad     = (cyc == 2);
					a.aluOutWrite = (cyc == 3);
					r.rfWrite     = (cyc == 3);
					r.regIn       = (cyc == 3);
				end
				classStore:
					m.memWrite = 1'b1;
				classBpz, classBz, classBnz:
				begin
					a.aluSrc2 = src2Branch;
					r.pcWrite = (cls == classBpz) ? ~nIn : (cls == classBz) ? zIn : ~zIn;
				end
				default:
				begin
					// stop and illegal write nothing
				end
			endcase
		end
	endfunction

	// --------------------
	// reporting
	// --------------------
	task automatic mismatch(input string what, input logic [31:0] expv, input logic [31:0] actv);
		errorCount++;
		testErrors++;
		$display("CHECK FAILED %s %s: expected %h, actual %h", testName, what, expv, actv);
	endtask

	task automatic problem(input string text);
		errorCount++;
		testErrors++;
		$display("ERROR in %s: %s", testName, text);
	endtask

	task automatic closeTest();
		testCount++;
		if (testErrors != 0)
			testFails++;
		$display("test %s: %s", testName, (testErrors == 0) ? "ok" : "FAILED");
		testErrors = 0;
	endtask

	task automatic printSummary();
		closeTest();    // the stop test is still open
		$display("%0d tests, %0d failed, %0d cycles checked, %0d errors",
			testCount, testFails, checkCount, errorCount);
	endtask

	task automatic compareWord(input memCtrlT m, input regCtrlT r, input aluCtrlT a);
		checkCount++;
		if (memCtrl !== m)
			mismatch("memCtrl", 32'(m), 32'(memCtrl));
		if (regCtrl !== r)
			mismatch("regCtrl", 32'(r), 32'(regCtrl));
		if (aluCtrl !== a)
			mismatch("aluCtrl", 32'(a), 32'(aluCtrl));
		if (counter !== edgeTally)
			mismatch("counter", 32'(edgeTally), 32'(counter));
	endtask

	// --------------------
	// cycle tracking
	// --------------------
	// sampled before the edge updates the state
	always @(posedge clock)
	begin
		if (reset)
		begin
			samples   = 0;
			edgeTally = '0;
			started   = 1'b0;
			idx       = 0;
			expLen    = 3;
			instrNo   = 0;
			curOp     = 4'b0000;
			stopSeen  = 1'b0;
			testName  = "reset";
			compareWord('0, '0, '0);
		end
		else
		begin
			samples++;
			if (regCtrl.irLoad)
			begin
				if (!started && samples != 2)
					problem($sformatf("first irLoad came %0d cycles after reset release, not 1",
						samples - 1));
				else if (started && idx + 1 != expLen)
					problem($sformatf("next irLoad after %0d cycles instead of %0d",
						idx + 1, expLen));
				closeTest();
				started  = 1'b1;
				instrNo++;
				idx      = 0;
				testName = $sformatf("instr %0d", instrNo);
			end
			else if (started)
				idx++;
			if (started && idx == 1)
			begin
				curOp    = instr;   // IR holds the new opcode from decode on
				testName = $sformatf("instr %0d op %b", instrNo, instr);
			end
			if (started)
				refControl(curOp, idx, n, z, expMem, expReg, expAlu, expLen);
			else
			begin
				expMem = '0;
				expReg = '0;
				expAlu = '0;
			end
			compareWord(expMem, expReg, expAlu);
			stopSeen = started && expLen == 0 && idx >= 2;
			if (!stopSeen)
				edgeTally++;
		end
	end

endmodule

/* source/controlUnit.sv */
// control unit top level
// opcode decoder, sequencer and control word generator

`timescale 1ns/10ps
`include "cpu_config.svh"

module controlUnit
	import isaPkg::*, controlPkg::*;
(
	input  logic                      clock,
	input  logic                      reset,
	input  opcodeT                    instr,
	input  logic                      n,
	input  logic                      z,
	output memCtrlT                   memCtrl,
	output regCtrlT                   regCtrl,
	output aluCtrlT                   aluCtrl,
	output logic [`COUNTER_WIDTH-1:0] counter
);

	instrClassT instrClass;
	aluOpT      arithOp;
	stateT      state;

	opcodeDecoder decoder
	(
		.instr      (instr),
		.instrClass (instrClass),
		.arithOp    (arithOp)
	);

	controlSequencer sequencer
	(
		.clock      (clock),
		.reset      (reset),
		.instrClass (instrClass),
		.state      (state),
		.counter    (counter)
	);

	controlWordGen wordGen
	(
		.state      (state),
		.arithOp    (arithOp),
		.n          (n),
		.z          (z),
		.memCtrl    (memCtrl),
		.regCtrl    (regCtrl),
		.aluCtrl    (aluCtrl)
	);

endmodule

/* source/controlWordGen.sv */
// control word generator
// memory, register file and ALU controls for each sequencer state
// branch condition from the n and z flags

`timescale 1ns/10ps

module controlWordGen
	import isaPkg::*, controlPkg::*;
(
	input  stateT   state,
	input  aluOpT   arithOp,
	input  logic    n,
	input  logic    z,
	output memCtrlT memCtrl,
	output regCtrlT regCtrl,
	output aluCtrlT aluCtrl
);

	always_comb
	begin
		// --------------------
		// defaults
		// --------------------
		memCtrl             = '0;
		regCtrl             = '0;
		aluCtrl.alu1        = 1'b0;
		aluCtrl.aluSrc2     = src2Reg;
		aluCtrl.aluOp       = aluAdd;
		aluCtrl.aluOutWrite = 1'b0;
		aluCtrl.flagWrite   = 1'b0;

		case (state)
			stFetch:
			begin
				// pc + 1 while the instruction is read
				regCtrl.pcWrite = 1'b1;
				regCtrl.irLoad  = 1'b1;
				memCtrl.addrSel = 1'b1;
				memCtrl.memRead = 1'b1;
				aluCtrl.aluSrc2 = src2One;
			end
			stDecode:
				regCtrl.r1R2Load = 1'b1;
			stArithExec:
			begin
				aluCtrl.alu1        = 1'b1;
				aluCtrl.aluOp       = arithOp;  // add, sub or nand
				aluCtrl.aluOutWrite = 1'b1;
				aluCtrl.flagWrite   = 1'b1;
			end
			stWriteBack:
				regCtrl.rfWrite = 1'b1;
			stShiftExec:
			begin
				aluCtrl.alu1        = 1'b1;
				aluCtrl.aluSrc2     = src2Shamt;
				aluCtrl.aluOp       = aluShift;
				aluCtrl.aluOutWrite = 1'b1;
				aluCtrl.flagWrite   = 1'b1;
			end
			stOriRead:
			begin
				regCtrl.r1Sel    = 1'b1;    // ori always targets k1
				regCtrl.r1R2Load = 1'b1;
			end
			stOriExec:
			begin
				aluCtrl.alu1        = 1'b1;
				aluCtrl.aluSrc2     = src2Imm;
				aluCtrl.aluOp       = aluOr;
				aluCtrl.aluOutWrite = 1'b1;
				aluCtrl.flagWrite   = 1'b1;
			end
			stOriWrite:
			begin
				regCtrl.r1Sel   = 1'b1;
				regCtrl.rfWrite = 1'b1;
			end
			stLoadRead:
			begin
				memCtrl.memRead = 1'b1;
				memCtrl.mdrLoad = 1'b1;
			end
			stLoadWrite:
			begin
				aluCtrl.aluOutWrite = 1'b1;
				regCtrl.rfWrite     = 1'b1;
				regCtrl.regIn       = 1'b1;     // data comes from MDR
			end
			stStore:
				memCtrl.memWrite = 1'b1;

			// --------------------
			// branches
			// --------------------
			// target is computed either way, pcWrite decides
			stBpz:
			begin
				aluCtrl.aluSrc2 = src2Branch;
				regCtrl.pcWrite = ~n;
			end
			stBz:
			begin
				aluCtrl.aluSrc2 = src2Branch;
				regCtrl.pcWrite = z;
			end
			stBnz:
			begin
				aluCtrl.aluSrc2 = src2Branch;
				regCtrl.pcWrite = ~z;
			end
			default:
			begin
				// reset and stop keep every control low
			end
		endcase
	end

	// single-ported memory
	always_comb
	begin
		memPortExclusive: assert (!(memCtrl.memRead && memCtrl.memWrite))
			else $error("memRead and memWrite together in %s", state.name());
	end

endmodule

/* source/controlSequencer.sv */
// multicycle sequencer
// state register, next-state table and free-running cycle counter
// stop-state checks

`timescale 1ns/10ps
`include "cpu_config.svh"

module controlSequencer
	import isaPkg::*, controlPkg::*;
(
	input  logic                      clock,
	input  logic                      reset,
	input  instrClassT                instrClass,
	output stateT                     state,
	output logic [`COUNTER_WIDTH-1:0] counter
);

	stateT nextState;

	// --------------------
	// next state
	// --------------------
	always_comb
	begin
		case (state)
			stReset:
				nextState = stFetch;
			stFetch:
				nextState = stDecode;
			stDecode:
			begin
				case (instrClass)
					classArith: nextState = stArithExec;
					classShift: nextState = stShiftExec;
					classOri:   nextState = stOriRead;
					classLoad:  nextState = stLoadRead;
					classStore: nextState = stStore;
					classBpz:   nextState = stBpz;
					classBz:    nextState = stBz;
					classBnz:   nextState = stBnz;
					classStop:  nextState = stStop;
					default:    nextState = stReset;    // illegal restarts the machine
				endcase
			end
			stArithExec, stShiftExec:
				nextState = stWriteBack;
			stOriRead:
				nextState = stOriExec;
			stOriExec:
				nextState = stOriWrite;
			stLoadRead:
				nextState = stLoadWrite;
			stStop:
				nextState = stStop;     // never leaves
			default:
				nextState = stFetch;    // last cycle of every other instruction
		endcase
	end

	// --------------------
	// state and counter
	// --------------------
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state   <= stReset;
			counter <= '0;
		end
		else
		begin
			state <= nextState;
			if (state != stStop)
				counter <= counter + 1'b1;  // frozen once stopped
		end
	end

	// stop is terminal and the counter freezes with it
	stopHolds: assert property (@(posedge clock) disable iff (reset)
		state == stStop |=> state == stStop && $stable(counter));

endmodule

/* source/opcodeDecoder.sv */
// opcode decoder
// instruction class and ALU operation from the IR opcode

`timescale 1ns/10ps

module opcodeDecoder
	import isaPkg::*;
(
	input  opcodeT     instr,
	output instrClassT instrClass,
	output aluOpT      arithOp
);

	// --------------------
	// class
	// --------------------
	always_comb
	begin
		if (instr[2:0] == 3'b011)
		begin
			instrClass = classShift;    // shift amount lives in the high bit
		end
		else if (instr[2:0] == 3'b111)
		begin
			instrClass = classOri;      // high bit is part of the immediate
		end
		else
		begin
			case (instr)
				opAdd, opSub, opNand:
					instrClass = classArith;
				opLoad:
					instrClass = classLoad;
				opStore:
					instrClass = classStore;
				opBpz:
					instrClass = classBpz;
				opBz:
					instrClass = classBz;
				opBnz:
					instrClass = classBnz;
				opStop:
					instrClass = classStop;
				default:
					instrClass = classIllegal;  // old vector codes land here
			endcase
		end
	end

	// --------------------
	// arith operation
	// --------------------
	// only consumed in the arith exec state
	always_comb
	begin
		case (instr)
			opAdd:   arithOp = aluAdd;
			opSub:   arithOp = aluSub;
			default: arithOp = aluNand;
		endcase
	end

endmodule

/* source/controlPkg.sv */
// control unit types
// sequencer states and the three control-word structs

package controlPkg;

	import isaPkg::*;

	// --------------------
	// sequencer states
	// --------------------
	typedef enum logic [3:0]
	{
		stReset,
		stFetch,        // common to every instruction
		stDecode,
		stArithExec,
		stWriteBack,    // shared by arith and shift
		stShiftExec,
		stOriRead,
		stOriExec,
		stOriWrite,
		stLoadRead,
		stLoadWrite,
		stStore,
		stBpz,
		stBz,
		stBnz,
		stStop          // terminal
	} stateT;

	// --------------------
	// control word
	// --------------------
	typedef struct packed
	{
		logic addrSel;      // pc as memory address
		logic memRead;
		logic memWrite;
		logic mdrLoad;
	} memCtrlT;

	typedef struct packed
	{
		logic pcWrite;
		logic irLoad;       // one cycle per instruction
		logic r1Sel;        // use R1 field for ori
		logic r1R2Load;
		logic rfWrite;
		logic regIn;        // write-back from MDR instead of ALUout
	} regCtrlT;

	typedef struct packed
	{
		logic    alu1;          // register operand, pc otherwise
		aluSrc2T aluSrc2;
		aluOpT   aluOp;
		logic    aluOutWrite;
		logic    flagWrite;     // update n and z
	} aluCtrlT;

endpackage

/* source/isaPkg.sv */
// instruction set types
// opcodes, instruction classes, ALU operations and second-operand selects

`include "cpu_config.svh"

package isaPkg;

	// fully coded opcodes only
	// shift and ori are recognised by their low three bits
	typedef enum logic [`INSTR_WIDTH-1:0]
	{
		opLoad  = 4'b0000,
		opStop  = 4'b0001,
		opStore = 4'b0010,
		opAdd   = 4'b0100,
		opBz    = 4'b0101,
		opSub   = 4'b0110,
		opNand  = 4'b1000,
		opBnz   = 4'b1001,
		opBpz   = 4'b1101
	} opcodeT;

	typedef enum logic [3:0]
	{
		classArith,     // add, sub, nand
		classShift,
		classOri,
		classLoad,
		classStore,
		classBpz,
		classBz,
		classBnz,
		classStop,
		classIllegal
	} instrClassT;

	typedef enum logic [`ALU_SEL_WIDTH-1:0]
	{
		aluAdd   = 3'b000,
		aluSub   = 3'b001,
		aluOr    = 3'b010,
		aluNand  = 3'b011,
		aluShift = 3'b100
	} aluOpT;

	typedef enum logic [`ALU_SEL_WIDTH-1:0]
	{
		src2Reg    = 3'b000,    // R2
		src2One    = 3'b001,    // pc increment
		src2Branch = 3'b010,    // sign-extended branch offset
		src2Imm    = 3'b011,    // ori immediate
		src2Shamt  = 3'b100     // shift amount field
	} aluSrc2T;

endpackage

/* source/cpu_config.svh */
// global widths for the control unit
// instruction, cycle counter and ALU select sizes

`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// --------------------
// instruction
// --------------------
`define INSTR_WIDTH 4       // opcode bits held in the IR

// --------------------
// cycle counter
// --------------------
`define COUNTER_WIDTH 16    // wraps silently

// --------------------
// datapath selects
// --------------------
// shared by the ALU operation and the second-operand mux
`define ALU_SEL_WIDTH 3

`endif
